// File: verilog/game_types_pkg.sv
`default_nettype none

package game_types_pkg;

	// one die face from 1 to 6
	typedef logic [2:0] die_t;
	// steps left in a move, at most 12
	typedef logic [3:0] move_t;
	typedef logic [4:0] spot_t;
	typedef logic [12:0] score_t;
	// size of one score change
	typedef logic [8:0] delta_t;
	// one flag per board spot
	typedef logic [31:0] visit_t;
	typedef logic [1:0] player_t;

	localparam int NUM_PLAYERS = 4;

	typedef enum logic [3:0] {
		S_TITLE,
		S_CLEAR,
		S_READY,
		S_ROLL_REL,
		S_STEP_WAIT,
		S_STEP_CHECK,
		S_SCORE,
		S_REPORT,
		S_NEXT,
		S_GAME_OVER
	} seq_state_t;

endpackage

`default_nettype wire

// File: verilog/board_rules_pkg.sv
`default_nettype none

package board_rules_pkg;

	localparam int BOARD_SPOTS = 32;
	localparam game_types_pkg::spot_t FINISH_SPOT = 5'd31;

	// per-pip amount on the bonus and penalty spots
	localparam int STOP_BONUS = 20;

	// spots 0 and 8 never change the score
	localparam game_types_pkg::visit_t ZERO_SPOTS = 32'h0000_0101;
	// spots 2 and 30
	localparam game_types_pkg::visit_t PENALTY_SPOTS = 32'h4000_0004;
	// spots 4, 12, 20 and 28
	localparam game_types_pkg::visit_t BONUS_SPOTS = 32'h1010_1010;
	// spots 16 and 24 pay their flat value on the first stop only
	localparam game_types_pkg::visit_t FLAT_SPOTS = 32'h0101_0000;

	// spots to visit before a player can finish, 31 included
	localparam game_types_pkg::visit_t FINISH_MASK = 32'hAEEE_EEEA;

	// base value per spot from index 0 up
	localparam game_types_pkg::delta_t SPOT_VALUE [BOARD_SPOTS] = '{
		// spots 0 to 7
		9'd0, 9'd5, 9'd0, 9'd15, 9'd0, 9'd15, 9'd10, 9'd20,
		// spots 8 to 15
		9'd0, 9'd20, 9'd30, 9'd30, 9'd0, 9'd40, 9'd40, 9'd50,
		// spots 16 to 23
		9'd150, 9'd40, 9'd40, 9'd40, 9'd0, 9'd10, 9'd60, 9'd60,
		// spots 24 to 31
		9'd300, 9'd10, 9'd30, 9'd60, 9'd0, 9'd80, 9'd0, 9'd80
	};

endpackage

`default_nettype wire

// File: verilog/step_timer.sv
`timescale 1ns/1ps
`default_nettype none

module step_timer #(
	parameter int STEP_CYCLES = 833333,
	parameter int FAST_STEP_CYCLES = 83333
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  run,
	input  wire  fast,
	output logic tick
);

	localparam int LONGEST = (STEP_CYCLES > FAST_STEP_CYCLES) ? STEP_CYCLES : FAST_STEP_CYCLES;
	localparam int CNT_W = $clog2(LONGEST) + 1;

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] reload;

	assign reload = fast ? CNT_W'(FAST_STEP_CYCLES - 1) : CNT_W'(STEP_CYCLES - 1);
	assign tick = run && (count == '0);

	// held at reload while idle so each step waits a full period
	always_ff @(posedge clk) begin
		if (!reset) begin
			count <= CNT_W'(STEP_CYCLES - 1);
		end else if (!run || tick) begin
			count <= reload;
		end else begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/spot_scorer.sv
`timescale 1ns/1ps
`default_nettype none

module spot_scorer (
	input  wire game_types_pkg::spot_t  spot,
	input  wire game_types_pkg::visit_t visits,
	input  wire game_types_pkg::die_t   max_die,
	output game_types_pkg::delta_t      delta,
	output logic                        negative
);

	game_types_pkg::delta_t bonus;
	game_types_pkg::delta_t scaled;

	// at most 20 x 6 or 80 x 6 which both fit in delta_t
	assign bonus = game_types_pkg::delta_t'(board_rules_pkg::STOP_BONUS * max_die);
	assign scaled = game_types_pkg::delta_t'(board_rules_pkg::SPOT_VALUE[spot] * max_die);

	always_comb begin
		delta = '0;
		negative = 1'b0;
		if (board_rules_pkg::ZERO_SPOTS[spot]) begin
			delta = '0;
		end else if (board_rules_pkg::PENALTY_SPOTS[spot]) begin
			delta = bonus;
			negative = 1'b1;
		end else if (board_rules_pkg::BONUS_SPOTS[spot]) begin
			delta = bonus;
		end else if (visits[spot]) begin
			// value spots only pay on the first stop
			delta = '0;
		end else if (board_rules_pkg::FLAT_SPOTS[spot]) begin
			delta = board_rules_pkg::SPOT_VALUE[spot];
		end else begin
			delta = scaled;
		end
	end

endmodule

`default_nettype wire

// File: verilog/player_store.sv
`timescale 1ns/1ps
`default_nettype none

module player_store (
	input  wire                                    clk,
	input  wire                                    reset,
	input  wire                                    clear_all,
	input  wire game_types_pkg::player_t           player,
	input  wire                                    step,
	input  wire                                    apply_score,
	input  wire                                    mark_finished,
	input  wire game_types_pkg::delta_t            delta,
	input  wire                                    negative,
	output game_types_pkg::spot_t                  spot,
	output game_types_pkg::score_t                 score,
	output game_types_pkg::visit_t                 visits,
	output logic                                   at_finish,
	output logic [game_types_pkg::NUM_PLAYERS-1:0] finished_mask
);

	localparam int SCORE_W = $bits(game_types_pkg::score_t);

	game_types_pkg::spot_t  spot_r  [game_types_pkg::NUM_PLAYERS];
	game_types_pkg::score_t score_r [game_types_pkg::NUM_PLAYERS];
	game_types_pkg::visit_t visit_r [game_types_pkg::NUM_PLAYERS];

	logic [SCORE_W:0]       sum;
	game_types_pkg::score_t new_score;

	assign spot = spot_r[player];
	assign score = score_r[player];
	assign visits = visit_r[player];

	assign at_finish = (spot == board_rules_pkg::FINISH_SPOT) &&
		((visits & board_rules_pkg::FINISH_MASK) == board_rules_pkg::FINISH_MASK);

	// score clamps at zero and at all ones
	always_comb begin
		sum = score + delta;
		if (negative) begin
			new_score = (score > delta) ? score - delta : '0;
		end else begin
			new_score = sum[SCORE_W] ? '1 : sum[SCORE_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset || clear_all) begin
			for (int i = 0; i < game_types_pkg::NUM_PLAYERS; i++) begin
				spot_r[i] <= '0;
				score_r[i] <= '0;
				visit_r[i] <= '0;
			end
			finished_mask <= '0;
		end else begin
			if (step) begin
				spot_r[player] <= game_types_pkg::spot_t'((spot + 1) % board_rules_pkg::BOARD_SPOTS);
			end
			if (apply_score) begin
				score_r[player] <= new_score;
				visit_r[player][spot] <= 1'b1;
			end
			if (mark_finished) begin
				finished_mask[player] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/turn_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module turn_sequencer (
	input  wire                                    clk,
	input  wire                                    reset,
	input  wire                                    start,
	input  wire                                    roll,
	input  wire                                    cancel,
	input  wire                                    fast_fwd,
	input  wire game_types_pkg::die_t              die_a,
	input  wire game_types_pkg::die_t              die_b,
	input  wire                                    tick,
	output logic                                   run,
	output logic                                   fast,
	output game_types_pkg::player_t                player,
	output game_types_pkg::die_t                   max_die,
	output logic                                   clear_all,
	output logic                                   step,
	output logic                                   apply_score,
	output logic                                   mark_finished,
	input  wire                                    at_finish,
	input  wire [game_types_pkg::NUM_PLAYERS-1:0]  finished_mask,
	input  wire game_types_pkg::spot_t             spot,
	input  wire game_types_pkg::score_t            score,
	output logic                                   ready,
	output logic                                   turn_done,
	output logic                                   game_over
);

	game_types_pkg::seq_state_t state;
	game_types_pkg::seq_state_t state_next;
	game_types_pkg::move_t      remaining;
	game_types_pkg::player_t    next_player;
	logic                       doubles;
	logic                       fin_turn;
	logic                       take_dice;
	logic                       no_change;

	assign clear_all = (state == game_types_pkg::S_CLEAR);
	assign ready = (state == game_types_pkg::S_READY);
	assign run = (state == game_types_pkg::S_STEP_WAIT);
	assign step = run && tick;
	assign mark_finished = (state == game_types_pkg::S_STEP_CHECK) && at_finish;
	assign apply_score = (state == game_types_pkg::S_SCORE);
	assign turn_done = (state == game_types_pkg::S_REPORT);
	assign game_over = (state == game_types_pkg::S_GAME_OVER);

	assign take_dice = (ready && fast_fwd) || (state == game_types_pkg::S_ROLL_REL && !roll);

	// stops that cannot move the score skip the score cycle
	assign no_change = board_rules_pkg::ZERO_SPOTS[spot] ||
		(board_rules_pkg::PENALTY_SPOTS[spot] && score == '0);

	// nearest unfinished player after the current one
	always_comb begin
		game_types_pkg::player_t cand;
		next_player = player;
		for (int i = game_types_pkg::NUM_PLAYERS - 1; i >= 1; i--) begin
			cand = player + game_types_pkg::player_t'(i);
			if (!finished_mask[cand]) begin
				next_player = cand;
			end
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			game_types_pkg::S_TITLE:
				if (start) state_next = game_types_pkg::S_CLEAR;
			game_types_pkg::S_CLEAR:
				state_next = game_types_pkg::S_READY;
			game_types_pkg::S_READY: begin
				if (fast_fwd) begin
					state_next = game_types_pkg::S_STEP_WAIT;
				end else if (cancel) begin
					state_next = game_types_pkg::S_TITLE;
				end else if (roll) begin
					state_next = game_types_pkg::S_ROLL_REL;
				end
			end
			game_types_pkg::S_ROLL_REL:
				if (!roll) state_next = game_types_pkg::S_STEP_WAIT;
			game_types_pkg::S_STEP_WAIT:
				if (tick) state_next = game_types_pkg::S_STEP_CHECK;
			game_types_pkg::S_STEP_CHECK: begin
				if (at_finish) begin
					state_next = game_types_pkg::S_REPORT;
				end else if (remaining == '0) begin
					state_next = no_change ? game_types_pkg::S_REPORT : game_types_pkg::S_SCORE;
				end else begin
					state_next = game_types_pkg::S_STEP_WAIT;
				end
			end
			game_types_pkg::S_SCORE:
				state_next = game_types_pkg::S_REPORT;
			game_types_pkg::S_REPORT:
				state_next = game_types_pkg::S_NEXT;
			game_types_pkg::S_NEXT:
				state_next = (&finished_mask) ? game_types_pkg::S_GAME_OVER : game_types_pkg::S_READY;
			game_types_pkg::S_GAME_OVER:
				if (cancel) state_next = game_types_pkg::S_TITLE;
			default:
				state_next = game_types_pkg::S_TITLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= game_types_pkg::S_TITLE;
			player <= '0;
			fast <= 1'b0;
			remaining <= '0;
			fin_turn <= 1'b0;
		end else begin
			state <= state_next;
			if (state == game_types_pkg::S_TITLE) begin
				player <= '0;
			end
			if (ready) begin
				fast <= fast_fwd;
			end
			if (take_dice) begin
				remaining <= game_types_pkg::move_t'(die_a) + game_types_pkg::move_t'(die_b);
				fin_turn <= 1'b0;
			end else if (step) begin
				remaining <= remaining - 1'b1;
			end
			if (mark_finished) begin
				fin_turn <= 1'b1;
			end
			// a double rolls again unless that player just finished
			if (state == game_types_pkg::S_NEXT && !(doubles && !fin_turn)) begin
				player <= next_player;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_dice) begin
			max_die <= (die_a > die_b) ? die_a : die_b;
			doubles <= (die_a == die_b);
		end
	end

endmodule

`default_nettype wire

// File: verilog/board_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_game_top #(
	parameter int STEP_CYCLES = 833333,
	parameter int FAST_STEP_CYCLES = 83333
) (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          start,
	input  wire                          roll,
	input  wire                          cancel,
	input  wire                          fast_fwd,
	input  wire game_types_pkg::die_t    die_a,
	input  wire game_types_pkg::die_t    die_b,
	output logic                         ready,
	output logic                         turn_done,
	output game_types_pkg::player_t      turn_player,
	output game_types_pkg::spot_t        turn_spot,
	output game_types_pkg::score_t       turn_score,
	output game_types_pkg::player_t      current_player,
	output logic                         game_over
);

	logic                                   run;
	logic                                   fast;
	logic                                   tick;
	logic                                   clear_all;
	logic                                   step;
	logic                                   apply_score;
	logic                                   mark_finished;
	logic                                   at_finish;
	logic                                   negative;
	game_types_pkg::player_t                player;
	game_types_pkg::die_t                   max_die;
	game_types_pkg::delta_t                 delta;
	game_types_pkg::spot_t                  spot;
	game_types_pkg::score_t                 score;
	game_types_pkg::visit_t                 visits;
	logic [game_types_pkg::NUM_PLAYERS-1:0] finished_mask;

	step_timer #(
		.STEP_CYCLES(STEP_CYCLES),
		.FAST_STEP_CYCLES(FAST_STEP_CYCLES)
	) u_step_timer (
		.clk(clk),
		.reset(reset),
		.run(run),
		.fast(fast),
		.tick(tick)
	);

	spot_scorer u_spot_scorer (
		.spot(spot),
		.visits(visits),
		.max_die(max_die),
		.delta(delta),
		.negative(negative)
	);

	player_store u_player_store (
		.clk(clk),
		.reset(reset),
		.clear_all(clear_all),
		.player(player),
		.step(step),
		.apply_score(apply_score),
		.mark_finished(mark_finished),
		.delta(delta),
		.negative(negative),
		.spot(spot),
		.score(score),
		.visits(visits),
		.at_finish(at_finish),
		.finished_mask(finished_mask)
	);

	turn_sequencer u_turn_sequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.roll(roll),
		.cancel(cancel),
		.fast_fwd(fast_fwd),
		.die_a(die_a),
		.die_b(die_b),
		.tick(tick),
		.run(run),
		.fast(fast),
		.player(player),
		.max_die(max_die),
		.clear_all(clear_all),
		.step(step),
		.apply_score(apply_score),
		.mark_finished(mark_finished),
		.at_finish(at_finish),
		.finished_mask(finished_mask),
		.spot(spot),
		.score(score),
		.ready(ready),
		.turn_done(turn_done),
		.game_over(game_over)
	);

	// store shows the mover's record as the finished turn while turn_done is high
	assign turn_player = player;
	assign turn_spot = spot;
	assign turn_score = score;
	assign current_player = player;

endmodule

`default_nettype wire

// File: tb/board_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_game_tb;

	localparam int STEP_CYCLES = 4;
	localparam int FAST_STEP_CYCLES = 2;
	localparam int TURN_LIMIT = 500;
	localparam int W_READY = 0;
	localparam int W_DONE = 1;
	localparam int W_OVER = 2;

	logic                    clk;
	logic                    reset;
	logic                    start;
	logic                    roll;
	logic                    cancel;
	logic                    fast_fwd;
	game_types_pkg::die_t    die_a;
	game_types_pkg::die_t    die_b;
	logic                    ready;
	logic                    turn_done;
	game_types_pkg::player_t turn_player;
	game_types_pkg::spot_t   turn_spot;
	game_types_pkg::score_t  turn_score;
	game_types_pkg::player_t current_player;
	logic                    game_over;

	// reference model of the four players
	int          m_spot [4];
	int          m_score [4];
	logic [31:0] m_visits [4];
	logic [3:0]  m_fin;
	int          m_player;
	int          exp_player;
	int          exp_spot;
	int          exp_score;

	integer seed;
	int     revisit_hits;
	int     clamp_hits;
	int     turns;
	int     sum;
	string  test_name;
	// dice pairs as two hex digits that steer player 0 onto a clamped penalty
	int     script [13] = '{'h12, 'h11, 'h23, 'h35, 'h12, 'h23, 'h22,
		'h13, 'h12, 'h13, 'h66, 'h55, 'h13};

	board_game_top #(
		.STEP_CYCLES(STEP_CYCLES),
		.FAST_STEP_CYCLES(FAST_STEP_CYCLES)
	) dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.roll(roll),
		.cancel(cancel),
		.fast_fwd(fast_fwd),
		.die_a(die_a),
		.die_b(die_b),
		.ready(ready),
		.turn_done(turn_done),
		.turn_player(turn_player),
		.turn_spot(turn_spot),
		.turn_score(turn_score),
		.current_player(current_player),
		.game_over(game_over)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// every reported turn against the model's prediction
	assert property (@(posedge clk) disable iff (!reset)
		turn_done |-> int'(turn_player) == exp_player)
		else fail_run($sformatf("mismatch %s turn_player expected %0d actual %0d",
			test_name, exp_player, turn_player));

	assert property (@(posedge clk) disable iff (!reset)
		turn_done |-> int'(turn_spot) == exp_spot)
		else fail_run($sformatf("mismatch %s turn_spot expected %0d actual %0d",
			test_name, exp_spot, turn_spot));

	assert property (@(posedge clk) disable iff (!reset)
		turn_done |-> int'(turn_score) == exp_score)
		else fail_run($sformatf("mismatch %s turn_score expected %0d actual %0d",
			test_name, exp_score, turn_score));

	task automatic check_value(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			fail_run($sformatf("mismatch %s %s expected %0d actual %0d",
				test_name, what, expected, actual));
		end
	endtask

	function automatic logic watched(input int which);
		case (which)
			W_READY: return ready;
			W_DONE: return turn_done;
			default: return game_over;
		endcase
	endfunction

	// returns on the falling edge where the level is first seen
	task automatic wait_signal(input int which, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!watched(which)) begin
			n++;
			if (n > limit) begin
				fail_run($sformatf("timeout in %s while waiting for %s", test_name, what));
			end
			@(negedge clk);
		end
	endtask

	function automatic int rand_die();
		return ($unsigned($random(seed)) % 6) + 1;
	endfunction

	task automatic predict_turn(input int a, input int b);
		int   p;
		int   k;
		int   pos;
		int   sc;
		int   high;
		int   bonus;
		logic fin;
		p = m_player;
		high = (a > b) ? a : b;
		bonus = board_rules_pkg::STOP_BONUS * high;
		pos = m_spot[p];
		sc = m_score[p];
		fin = 1'b0;
		// finish is tested on every step and not only at the stop
		for (k = 0; k < a + b && !fin; k++) begin
			pos = (pos + 1) % 32;
			fin = (pos == 31) && ((m_visits[p] & board_rules_pkg::FINISH_MASK) ==
				board_rules_pkg::FINISH_MASK);
		end
		if (!fin && pos != 0 && pos != 8) begin
			if (pos == 2 || pos == 30) begin
				if (sc > 0 && sc < bonus) clamp_hits++;
				sc = (sc > bonus) ? sc - bonus : 0;
			end else if (pos % 8 == 4) begin
				sc = sc + bonus;
			end else if (m_visits[p][pos]) begin
				revisit_hits++;
			end else if (pos == 16 || pos == 24) begin
				sc = sc + int'(board_rules_pkg::SPOT_VALUE[pos]);
			end else begin
				sc = sc + int'(board_rules_pkg::SPOT_VALUE[pos]) * high;
			end
			if (sc > 8191) sc = 8191;
			m_visits[p][pos] = 1'b1;
		end
		if (fin) m_fin[p] = 1'b1;
		m_spot[p] = pos;
		m_score[p] = sc;
		exp_player = p;
		exp_spot = pos;
		exp_score = sc;
		// nearest unfinished player unless a double lets p go again
		if (a != b || fin) begin
			for (k = 3; k >= 1; k--) begin
				if (!m_fin[(p + k) % 4]) m_player = (p + k) % 4;
			end
		end
	endtask

	// called on a falling edge with ready high
	task automatic play_turn(input int a, input int b, input logic use_roll);
		predict_turn(a, b);
		die_a = game_types_pkg::die_t'(a);
		die_b = game_types_pkg::die_t'(b);
		if (use_roll) begin
			roll = 1'b1;
			@(negedge clk);
			roll = 1'b0;
		end
		wait_signal(W_DONE, TURN_LIMIT, "turn_done");
		if (&m_fin) begin
			wait_signal(W_OVER, 3, "game_over");
			check_value("ready", 0, ready);
		end else begin
			wait_signal(W_READY, 3, "ready");
			check_value("current_player", m_player, current_player);
			check_value("game_over", 0, game_over);
		end
	endtask

	// aim at the nearest unvisited finish spot without stopping one short of it
	function automatic int pick_sum();
		int d;
		int s;
		int near;
		near = 0;
		for (d = 31; d >= 2; d--) begin
			s = (m_spot[m_player] + d) % 32;
			if (board_rules_pkg::FINISH_MASK[s] && !m_visits[m_player][s]) near = d;
		end
		if (near == 0 || near - 2 > 12) begin
			return 12;
		end else if (near <= 12) begin
			return near;
		end else begin
			return near - 2;
		end
	endfunction

	task automatic start_game();
		int i;
		for (i = 0; i < 4; i++) begin
			m_spot[i] = 0;
			m_score[i] = 0;
			m_visits[i] = '0;
		end
		m_fin = '0;
		m_player = 0;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_signal(W_READY, 3, "ready after start");
		check_value("current_player", 0, current_player);
		check_value("game_over", 0, game_over);
	endtask

	initial begin
		int i;
		seed = 32'hd135;
		revisit_hits = 0;
		clamp_hits = 0;
		test_name = "reset";
		reset = 1'b0;
		start = 1'b0;
		roll = 1'b0;
		cancel = 1'b0;
		fast_fwd = 1'b0;
		die_a = 3'd1;
		die_b = 3'd1;
		repeat (10) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		check_value("ready", 0, ready);
		check_value("turn_done", 0, turn_done);
		check_value("game_over", 0, game_over);
		check_value("current_player", 0, current_player);

		test_name = "start";
		start_game();
		test_name = "scripted roll";
		for (i = 0; i < 13; i++) begin
			play_turn(script[i] >> 4, script[i] & 'hf, 1'b1);
		end
		test_name = "random roll";
		repeat (6) play_turn(rand_die(), rand_die(), 1'b1);

		// dice are taken straight from ready while roll stays low
		test_name = "fast forward";
		fast_fwd = 1'b1;
		repeat (8) play_turn(rand_die(), rand_die(), 1'b0);

		test_name = "finish";
		turns = 0;
		while (!(&m_fin)) begin
			sum = pick_sum();
			play_turn(sum / 2, sum - sum / 2, 1'b0);
			turns++;
			if (turns > 2000) fail_run("the game did not end after 2000 chosen turns");
		end

		test_name = "cancel";
		fast_fwd = 1'b0;
		cancel = 1'b1;
		@(negedge clk);
		cancel = 1'b0;
		check_value("game_over", 0, game_over);
		check_value("ready", 0, ready);
		test_name = "restart";
		start_game();
		play_turn(2, 3, 1'b1);

		assert (revisit_hits > 0) else fail_run("no turn stopped on a revisited value spot");
		assert (clamp_hits > 0) else fail_run("no penalty stop clamped a score at zero");
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: board_game.f
verilog/game_types_pkg.sv
verilog/board_rules_pkg.sv
verilog/step_timer.sv
verilog/spot_scorer.sv
verilog/player_store.sv
verilog/turn_sequencer.sv
verilog/board_game_top.sv
tb/board_game_tb.sv

// File: Bender.yml
package:
  name: board_game

sources:
  - verilog/game_types_pkg.sv
  - verilog/board_rules_pkg.sv
  - verilog/step_timer.sv
  - verilog/spot_scorer.sv
  - verilog/player_store.sv
  - verilog/turn_sequencer.sv
  - verilog/board_game_top.sv
  - target: test
    files:
      - tb/board_game_tb.sv
